// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    // ----------------------------------------
    // Line geometry
    // ----------------------------------------

    // Address and data word width
    localparam int addr_w = 32;
    // Words held by the single line
    localparam int line_words = 16;
    // Word index inside the line, address bits 5:2
    localparam int word_idx_w = 4;
    // Tag sits right above the line offset
    localparam int tag_lsb = 6;

    // ----------------------------------------
    // Burst channel constants
    // ----------------------------------------

    // Burst length field, beats minus one
    localparam logic [7:0] burst_len = 8'(line_words - 1);
    // Write response code for a good transfer
    localparam logic [1:0] resp_okay = 2'b00;

    // Miss and flush sequencer states
    typedef enum logic [2:0] {
        idle,
        wb_addr,
        wb_data,
        wb_resp,
        rf_addr,
        rf_data
    } ctrl_state_t;

    // One CPU request, held until stall drops
    typedef struct packed {
        logic [addr_w-1:0] address;
        logic [addr_w-1:0] write_data;
        logic              read_enable;
        logic              write_enable;
        logic [3:0]        byte_enable;
    } cpu_req_t;

    // Address channel, master to slave
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] addr;
        logic [7:0]        len;
    } burst_addr_t;

    // Write data beat, master to slave
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] data;
        logic              last;
    } wbeat_t;

    // Read data beat, slave to master
    typedef struct packed {
        logic              valid;
        logic [addr_w-1:0] data;
        logic              last;
    } rbeat_t;

    // Write response, slave to master
    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } bresp_t;

endpackage

`default_nettype wire

// ==== rtl/dcache_line_store.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_line_store (
    input  wire logic                                            clk,
    input  wire logic                                            rst_n,
    // CPU request, address and write payload
    input  wire dcache_pkg::cpu_req_t                            req,
    // Write strobes from the controller
    input  wire logic                                            cpu_we,
    input  wire logic                                            refill_we,
    input  wire logic [dcache_pkg::addr_w-1:0]                   refill_data,
    input  wire logic [dcache_pkg::word_idx_w-1:0]               beat_ptr,
    input  wire logic                                            fill_done,
    input  wire logic                                            flush_done,
    // Line status back to the controller
    output logic                                                 hit,
    output logic                                                 dirty,
    output logic [dcache_pkg::addr_w-1:dcache_pkg::tag_lsb]      stored_tag,
    // Data outputs
    output logic [dcache_pkg::addr_w-1:0]                        read_data,
    output logic [dcache_pkg::addr_w-1:0]                        beat_word
);

    // ----------------------------------------
    // Line storage
    // ----------------------------------------

    // Sixteen data words of the resident block
    logic [dcache_pkg::line_words-1:0][dcache_pkg::addr_w-1:0] words;
    // Tag of the resident block
    logic [dcache_pkg::addr_w-1:dcache_pkg::tag_lsb]           tag;
    // Line holds a fetched block
    logic                                                      valid;

    // Word selected by the request
    logic [dcache_pkg::word_idx_w-1:0] req_idx;
    // Byte lane mask from the four enables
    logic [dcache_pkg::addr_w-1:0]     byte_mask;
    // Old word with the enabled bytes replaced
    logic [dcache_pkg::addr_w-1:0]     merged_word;

    assign req_idx = req.address[dcache_pkg::tag_lsb-1 -: dcache_pkg::word_idx_w];

    // ----------------------------------------
    // Hit compare and reads
    // ----------------------------------------

    // Single line, so a hit is valid plus a tag match
    assign hit = valid && (req.address[dcache_pkg::addr_w-1:dcache_pkg::tag_lsb] == tag);

    assign stored_tag = tag;

    // Asynchronous read for the CPU
    assign read_data = words[req_idx];

    // Word feeding the write-back beats
    assign beat_word = words[beat_ptr];

    // ----------------------------------------
    // Byte merge
    // ----------------------------------------

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            byte_mask[8*i +: 8] = {8{req.byte_enable[i]}};
        end
    end

    // Keep disabled lanes, take enabled lanes from the CPU
    assign merged_word = (words[req_idx] & ~byte_mask) | (req.write_data & byte_mask);

    // ----------------------------------------
    // Writes
    // ----------------------------------------

    // Refill beats and CPU write hits share the array
    always_ff @(posedge clk) begin
        if (refill_we) begin
            words[beat_ptr] <= refill_data;
        end else if (cpu_we) begin
            words[req_idx] <= merged_word;
        end
    end

    // New tag taken with the last refill beat
    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag <= req.address[dcache_pkg::addr_w-1:dcache_pkg::tag_lsb];
        end
    end

    // Valid and dirty flags
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            if (fill_done) begin
                // Fresh block from memory is clean
                valid <= 1'b1;
                dirty <= 1'b0;
            end else if (flush_done) begin
                // Memory now matches the line
                dirty <= 1'b0;
            end else if (cpu_we) begin
                dirty <= 1'b1;
            end
        end
    end

    // CPU writes only happen in idle, refills only during a burst
    assert property (@(posedge clk) disable iff (!rst_n) !(cpu_we && refill_we))
        else $error("dcache_line_store: cpu write and refill in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/dcache_burst_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_burst_ctrl (
    input  wire logic                                       clk,
    input  wire logic                                       rst_n,
    // CPU side
    input  wire dcache_pkg::cpu_req_t                       req,
    input  wire logic                                       csr_flush_order,
    output logic                                            cache_stall,
    // Line store status
    input  wire logic                                       hit,
    input  wire logic                                       dirty,
    input  wire logic [dcache_pkg::addr_w-1:dcache_pkg::tag_lsb] stored_tag,
    input  wire logic [dcache_pkg::addr_w-1:0]              beat_word,
    // Line store controls
    output logic                                            cpu_we,
    output logic                                            refill_we,
    output logic [dcache_pkg::addr_w-1:0]                   refill_data,
    output logic [dcache_pkg::word_idx_w-1:0]               beat_ptr,
    output logic                                            fill_done,
    output logic                                            flush_done,
    // Burst master channels
    output dcache_pkg::burst_addr_t                         aw,
    input  wire logic                                       aw_ready,
    output dcache_pkg::wbeat_t                              w,
    input  wire logic                                       w_ready,
    input  wire dcache_pkg::bresp_t                         b,
    output logic                                            b_ready,
    output dcache_pkg::burst_addr_t                         ar,
    input  wire logic                                       ar_ready,
    input  wire dcache_pkg::rbeat_t                         r,
    output logic                                            r_ready
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t next_state;

    // Write-back was started by a CSR flush, not a miss
    logic flushing;
    logic next_flushing;

    logic [dcache_pkg::word_idx_w-1:0] next_ptr;

    // Request decode
    logic rd_req;
    logic wr_req;
    logic any_req;
    logic miss;

    // ----------------------------------------
    // Request decode and stall
    // ----------------------------------------

    assign rd_req = req.read_enable;
    // All enables low means nothing to write
    assign wr_req = req.write_enable && (|req.byte_enable);
    assign any_req = rd_req || wr_req;
    assign miss = any_req && !hit;

    // Stall on a miss right away, and for as long as a burst runs
    assign cache_stall = (state != dcache_pkg::idle) || miss;

    // Write hits are served in idle only
    assign cpu_we = (state == dcache_pkg::idle) && wr_req && hit;

    // Refill beats go straight into the line
    assign refill_data = r.data;
    assign refill_we = (state == dcache_pkg::rf_data) && r.valid;
    assign fill_done = refill_we && r.last;

    // Accepted response means memory holds the line
    assign flush_done = (state == dcache_pkg::wb_resp) && b.valid;

    // ----------------------------------------
    // Next state and channel drive
    // ----------------------------------------

    always_comb begin
        next_state = state;
        next_flushing = flushing;
        next_ptr = beat_ptr;

        // Payloads stay stable, valids only in their own state
        aw.valid = 1'b0;
        aw.addr = {stored_tag, {dcache_pkg::tag_lsb{1'b0}}};
        aw.len = dcache_pkg::burst_len;

        w.valid = 1'b0;
        w.data = beat_word;
        w.last = (beat_ptr == dcache_pkg::word_idx_w'(dcache_pkg::line_words - 1));

        ar.valid = 1'b0;
        ar.addr = {req.address[dcache_pkg::addr_w-1:dcache_pkg::tag_lsb],
                   {dcache_pkg::tag_lsb{1'b0}}};
        ar.len = dcache_pkg::burst_len;

        b_ready = 1'b0;
        r_ready = 1'b0;

        case (state)
            dcache_pkg::idle: begin
                next_ptr = '0;
                if (miss) begin
                    // Dirty victim goes out before the refill
                    next_flushing = 1'b0;
                    if (dirty) begin
                        next_state = dcache_pkg::wb_addr;
                    end else begin
                        next_state = dcache_pkg::rf_addr;
                    end
                end else if (csr_flush_order && !any_req && dirty) begin
                    // Clean line has nothing to write back
                    next_flushing = 1'b1;
                    next_state = dcache_pkg::wb_addr;
                end
            end

            dcache_pkg::wb_addr: begin
                aw.valid = 1'b1;
                if (aw_ready) begin
                    next_state = dcache_pkg::wb_data;
                end
            end

            dcache_pkg::wb_data: begin
                w.valid = 1'b1;
                if (w_ready) begin
                    // Pointer wraps back to zero after beat 15
                    next_ptr = beat_ptr + 1'b1;
                    if (w.last) begin
                        next_state = dcache_pkg::wb_resp;
                    end
                end
            end

            dcache_pkg::wb_resp: begin
                b_ready = 1'b1;
                if (b.valid) begin
                    if (flushing) begin
                        next_flushing = 1'b0;
                        next_state = dcache_pkg::idle;
                    end else begin
                        next_state = dcache_pkg::rf_addr;
                    end
                end
            end

            dcache_pkg::rf_addr: begin
                ar.valid = 1'b1;
                if (ar_ready) begin
                    next_state = dcache_pkg::rf_data;
                end
            end

            dcache_pkg::rf_data: begin
                r_ready = 1'b1;
                if (r.valid) begin
                    next_ptr = beat_ptr + 1'b1;
                    // Back to idle, the held request now hits
                    if (r.last) begin
                        next_state = dcache_pkg::idle;
                    end
                end
            end

            default: begin
                next_state = dcache_pkg::idle;
            end
        endcase
    end

    // ----------------------------------------
    // State registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= dcache_pkg::idle;
            flushing <= 1'b0;
            beat_ptr <= '0;
        end else begin
            state <= next_state;
            flushing <= next_flushing;
            beat_ptr <= next_ptr;
        end
    end

    // Slave must accept the write-back
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == dcache_pkg::wb_resp && b.valid) |-> (b.resp == dcache_pkg::resp_okay))
        else $error("dcache_burst_ctrl: write-back response %0d is not OKAY", b.resp);

    // CPU never reads and writes in one request
    assert property (@(posedge clk) disable iff (!rst_n)
        !(req.read_enable && req.write_enable))
        else $error("dcache_burst_ctrl: read and write requested together");

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    // CPU port
    input  wire dcache_pkg::cpu_req_t          cpu_req,
    input  wire logic                          csr_flush_order,
    output logic [dcache_pkg::addr_w-1:0]      read_data,
    output logic                               cache_stall,
    // Memory burst port
    output dcache_pkg::burst_addr_t            aw,
    input  wire logic                          aw_ready,
    output dcache_pkg::wbeat_t                 w,
    input  wire logic                          w_ready,
    input  wire dcache_pkg::bresp_t            b,
    output logic                               b_ready,
    output dcache_pkg::burst_addr_t            ar,
    input  wire logic                          ar_ready,
    input  wire dcache_pkg::rbeat_t            r,
    output logic                               r_ready
);

    // ----------------------------------------
    // Store to controller
    // ----------------------------------------

    logic                                            hit;
    logic                                            dirty;
    logic [dcache_pkg::addr_w-1:dcache_pkg::tag_lsb] stored_tag;
    logic [dcache_pkg::addr_w-1:0]                   beat_word;

    // Controller to store
    logic                                            cpu_we;
    logic                                            refill_we;
    logic [dcache_pkg::addr_w-1:0]                   refill_data;
    logic [dcache_pkg::word_idx_w-1:0]               beat_ptr;
    logic                                            fill_done;
    logic                                            flush_done;

    // Data words, tag and flags
    dcache_line_store u_line_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (cpu_req),
        .cpu_we      (cpu_we),
        .refill_we   (refill_we),
        .refill_data (refill_data),
        .beat_ptr    (beat_ptr),
        .fill_done   (fill_done),
        .flush_done  (flush_done),
        .hit         (hit),
        .dirty       (dirty),
        .stored_tag  (stored_tag),
        .read_data   (read_data),
        .beat_word   (beat_word)
    );

    // Miss, write-back and flush sequencing
    dcache_burst_ctrl u_burst_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .req             (cpu_req),
        .csr_flush_order (csr_flush_order),
        .cache_stall     (cache_stall),
        .hit             (hit),
        .dirty           (dirty),
        .stored_tag      (stored_tag),
        .beat_word       (beat_word),
        .cpu_we          (cpu_we),
        .refill_we       (refill_we),
        .refill_data     (refill_data),
        .beat_ptr        (beat_ptr),
        .fill_done       (fill_done),
        .flush_done      (flush_done),
        .aw              (aw),
        .aw_ready        (aw_ready),
        .w               (w),
        .w_ready         (w_ready),
        .b               (b),
        .b_ready         (b_ready),
        .ar              (ar),
        .ar_ready        (ar_ready),
        .r               (r),
        .r_ready         (r_ready)
    );

endmodule

`default_nettype wire

// ==== bench/mem_burst_model.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_burst_model (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    // Write address and data from the cache
    input  wire dcache_pkg::burst_addr_t aw,
    output logic                         aw_ready,
    input  wire dcache_pkg::wbeat_t      w,
    output logic                         w_ready,
    // Write response back to the cache
    output dcache_pkg::bresp_t           b,
    input  wire logic                    b_ready,
    // Refill address and data
    input  wire dcache_pkg::burst_addr_t ar,
    output logic                         ar_ready,
    output dcache_pkg::rbeat_t           r,
    input  wire logic                    r_ready
);

    // 1 KB of word storage, address bits 9:2
    localparam int mem_words = 256;
    // Preset pattern, XORed with each word's own address
    localparam logic [31:0] fill_key = 32'h5a5a_c3c3;

    // Word array, inspected by the testbench
    logic [31:0] mem [mem_words];

    integer seed = 32'h62ef_5579;

    // Next word of the running write burst
    logic [7:0] wr_idx;
    // Next word and beat count of the running read burst
    logic [7:0] rd_idx;
    logic [3:0] rd_cnt;
    logic       rd_active;
    // Random go bit for the current read beat
    logic       r_go;

    // Ready about three cycles out of four
    function automatic logic draw_ready();
        return (($random(seed) & 32'sd3) != 32'sd0);
    endfunction

    // ----------------------------------------
    // Read beats
    // ----------------------------------------

    // Payload follows the beat pointer and stays put while valid waits
    always_comb begin
        r.valid = rd_active && r_go;
        r.data  = mem[rd_idx];
        r.last  = (rd_cnt == 4'd15);
    end

    // ----------------------------------------
    // Channel handshakes and storage
    // ----------------------------------------

    always @(posedge clk) begin
        if (!rst_n) begin
            // Whole array back to the preset pattern
            for (int i = 0; i < mem_words; i++) begin
                mem[i] <= 32'(i * 4) ^ fill_key;
            end
            aw_ready  <= 1'b0;
            w_ready   <= 1'b0;
            ar_ready  <= 1'b0;
            b         <= '0;
            wr_idx    <= '0;
            rd_idx    <= '0;
            rd_cnt    <= '0;
            rd_active <= 1'b0;
            r_go      <= 1'b0;
        end else begin
            aw_ready <= draw_ready();
            w_ready  <= draw_ready();
            ar_ready <= draw_ready();

            // Write burst start
            if (aw.valid && aw_ready) begin
                wr_idx <= aw.addr[9:2];
            end

            // One word per accepted write beat
            if (w.valid && w_ready) begin
                mem[wr_idx] <= w.data;
                wr_idx <= wr_idx + 8'd1;
                if (w.last) begin
                    b.valid <= 1'b1;
                    b.resp  <= dcache_pkg::resp_okay;
                end
            end

            // Response held until taken
            if (b.valid && b_ready) begin
                b.valid <= 1'b0;
            end

            // Read burst start
            if (ar.valid && ar_ready) begin
                rd_active <= 1'b1;
                rd_idx    <= ar.addr[9:2];
                rd_cnt    <= '0;
            end

            // Step through the line, stop after beat 15
            if (r.valid && r_ready) begin
                rd_idx <= rd_idx + 8'd1;
                rd_cnt <= rd_cnt + 4'd1;
                if (rd_cnt == 4'd15) begin
                    rd_active <= 1'b0;
                end
            end

            // A waiting beat keeps valid high, otherwise draw again
            r_go <= (r.valid && !r_ready) ? 1'b1 : draw_ready();
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_dcache.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int clk_period = 40;
    localparam int mem_words = 256;
    localparam int cycles_per_row = 400;
    // Same preset rule as the memory model
    localparam logic [31:0] fill_key = 32'h5a5a_c3c3;

    typedef enum logic [1:0] {
        op_read,
        op_write,
        op_flush
    } op_t;

    // One table row whose exp field only matters for reads
    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;
        logic [31:0] exp;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    dcache_pkg::cpu_req_t    cpu_req;
    logic                    csr_flush_order;
    logic [31:0]             read_data;
    logic                    cache_stall;
    dcache_pkg::burst_addr_t aw;
    dcache_pkg::burst_addr_t ar;
    dcache_pkg::wbeat_t      w;
    dcache_pkg::bresp_t      b;
    dcache_pkg::rbeat_t      r;
    logic                    aw_ready;
    logic                    w_ready;
    logic                    b_ready;
    logic                    ar_ready;
    logic                    r_ready;

    row_t        rows[$];
    // Shadow of the memory as the CPU sees it
    logic [31:0] shadow [mem_words];
    integer      seed = 32'h62ef_5579;
    int          errors = 0;
    int          checks = 0;
    logic        table_ready = 1'b0;

    // Expected line contents tracked from the cache rules
    logic        line_valid;
    logic        line_dirty;
    logic [31:0] line_base;

    always #(clk_period / 2) clk = ~clk;

    dcache_top u_dcache_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_req         (cpu_req),
        .csr_flush_order (csr_flush_order),
        .read_data       (read_data),
        .cache_stall     (cache_stall),
        .aw              (aw),
        .aw_ready        (aw_ready),
        .w               (w),
        .w_ready         (w_ready),
        .b               (b),
        .b_ready         (b_ready),
        .ar              (ar),
        .ar_ready        (ar_ready),
        .r               (r),
        .r_ready         (r_ready)
    );

    mem_burst_model u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw       (aw),
        .aw_ready (aw_ready),
        .w        (w),
        .w_ready  (w_ready),
        .b        (b),
        .b_ready  (b_ready),
        .ar       (ar),
        .ar_ready (ar_ready),
        .r        (r),
        .r_ready  (r_ready)
    );

    // ----------------------------------------
    // Shadow memory
    // ----------------------------------------

    // Enabled byte lanes come from the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic reset_shadow();
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = 32'(i * 4) ^ fill_key;
        end
    endtask

    // Read rows take their expected value from the shadow at this point
    task automatic add_row(input op_t op, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] be);
        row_t row;
        row.op = op;
        row.addr = addr;
        row.wdata = wdata;
        row.be = be;
        row.exp = shadow[addr[9:2]];
        if (op == op_write) begin
            shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], wdata, be);
        end
        rows.push_back(row);
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------

    task automatic build_table();
        logic [31:0] data;
        logic [3:0]  be;
        // Cold miss on block 0x000 then hits on the other words
        for (int i = 0; i < 16; i++) begin
            add_row(op_read, 32'(4 * i), '0, '0);
        end
        // Miss at a mid-line offset with a clean victim
        add_row(op_read, 32'h114, '0, '0);
        add_row(op_read, 32'h13c, '0, '0);
        add_row(op_read, 32'h100, '0, '0);
        // Byte merges into the resident block
        add_row(op_write, 32'h104, 32'h1122_3344, 4'b0001);
        add_row(op_write, 32'h108, 32'h5566_7788, 4'b0110);
        add_row(op_write, 32'h10c, 32'h99aa_bbcc, 4'b1111);
        add_row(op_write, 32'h110, 32'hddee_ff00, 4'b1000);
        add_row(op_write, 32'h104, 32'hcafe_f00d, 4'b0100);
        // All enables low counts as no request
        add_row(op_write, 32'h13c, 32'hdead_beef, 4'b0000);
        add_row(op_read, 32'h104, '0, '0);
        add_row(op_read, 32'h108, '0, '0);
        add_row(op_read, 32'h10c, '0, '0);
        add_row(op_read, 32'h110, '0, '0);
        add_row(op_read, 32'h13c, '0, '0);
        // Other tag while dirty forces a write-back first
        add_row(op_read, 32'h2c8, '0, '0);
        add_row(op_read, 32'h2c0, '0, '0);
        add_row(op_read, 32'h2fc, '0, '0);
        // Old block returns with the merged words
        add_row(op_read, 32'h104, '0, '0);
        add_row(op_read, 32'h108, '0, '0);
        add_row(op_read, 32'h10c, '0, '0);
        add_row(op_read, 32'h110, '0, '0);
        // Flush after dirty writes and once more on a clean line
        add_row(op_write, 32'h120, 32'h0bad_f00d, 4'b0011);
        add_row(op_write, 32'h13c, 32'h7654_3210, 4'b1111);
        add_row(op_flush, '0, '0, '0);
        add_row(op_read, 32'h120, '0, '0);
        add_row(op_flush, '0, '0, '0);
        // Random data and enables where the first write misses
        for (int i = 0; i < 8; i++) begin
            data = 32'($random(seed));
            be = 4'($random(seed));
            add_row(op_write, 32'h300 + 32'(8 * i), data, be);
        end
        for (int i = 0; i < 8; i++) begin
            add_row(op_read, 32'h300 + 32'(8 * i), '0, '0);
        end
        // Write miss with a dirty victim
        add_row(op_write, 32'h01c, 32'h5a17_e0c4, 4'b1111);
        add_row(op_flush, '0, '0, '0);
        add_row(op_read, 32'h01c, '0, '0);
    endtask

    // ----------------------------------------
    // Checks and row driver
    // ----------------------------------------

    // Model array against the shadow for one block
    task automatic check_block(input logic [31:0] base);
        logic [7:0] idx;
        for (int k = 0; k < 16; k++) begin
            idx = base[9:2] + 8'(k);
            checks++;
            assert (u_mem.mem[idx] === shadow[idx]) else begin
                errors++;
                $display("[FAIL] mem[%02h] at %08h: got %08h, expected %08h",
                         idx, {base[31:6], 6'd0} + 32'(4 * k), u_mem.mem[idx], shadow[idx]);
            end
        end
    endtask

    // Burst addresses and lengths seen on each accepted address beat
    always @(negedge clk) begin
        if (rst_n && aw.valid && aw_ready) begin
            checks++;
            // Victim block, sixteen beats so len reads fifteen
            assert ({aw.addr, aw.len} === {line_base, 8'h0f}) else begin
                errors++;
                $display("[FAIL] aw: got addr %08h len %02h, expected addr %08h len %02h",
                         aw.addr, aw.len, line_base, 8'h0f);
            end
        end
        if (rst_n && ar.valid && ar_ready) begin
            checks++;
            // Block of the held request
            assert ({ar.addr, ar.len} === {cpu_req.address[31:6], 6'd0, 8'h0f}) else begin
                errors++;
                $display("[FAIL] ar: got addr %08h len %02h, expected addr %08h len %02h",
                         ar.addr, ar.len, {cpu_req.address[31:6], 6'd0}, 8'h0f);
            end
        end
    end

    // Called and returns 1 ns after a rising edge
    task automatic run_row(input row_t row);
        logic [31:0] block;
        logic [31:0] wb_block;
        logic        wb_due;
        logic        is_req;
        logic        miss;
        logic        stall_exp;
        block = {row.addr[31:6], 6'd0};
        wb_block = line_base;
        is_req = (row.op == op_read) || (row.op == op_write && row.be != 4'd0);
        miss = !line_valid || (block != line_base);
        stall_exp = is_req && miss;
        // Flush always leaves memory equal to the shadow
        wb_due = (row.op == op_flush) ? line_valid : (is_req && miss && line_valid && line_dirty);
        cpu_req = '0;
        csr_flush_order = 1'b0;
        case (row.op)
            op_read: begin
                cpu_req.address = row.addr;
                cpu_req.read_enable = 1'b1;
            end
            op_write: begin
                cpu_req.address = row.addr;
                cpu_req.write_data = row.wdata;
                cpu_req.write_enable = 1'b1;
                cpu_req.byte_enable = row.be;
            end
            default: begin
                csr_flush_order = 1'b1;
                @(posedge clk);
                #1;
                csr_flush_order = 1'b0;
            end
        endcase
        // Stall is sampled mid-cycle
        @(negedge clk);
        // Stall rises in the request cycle on a miss only
        if (row.op != op_flush) begin
            checks++;
            assert (cache_stall === stall_exp) else begin
                errors++;
                $display("[FAIL] cache_stall at %08h: got %h, expected %h",
                         row.addr, cache_stall, stall_exp);
            end
        end
        while (cache_stall) begin
            @(negedge clk);
        end
        if (row.op == op_read) begin
            checks++;
            assert (read_data === row.exp) else begin
                errors++;
                $display("[FAIL] read_data at %08h: got %08h, expected %08h",
                         row.addr, read_data, row.exp);
            end
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
        if (row.op == op_write) begin
            shadow[row.addr[9:2]] = merge_bytes(shadow[row.addr[9:2]], row.wdata, row.be);
        end
        if (is_req) begin
            line_dirty = (row.op == op_write) || (line_dirty && !miss);
            line_valid = 1'b1;
            line_base = block;
        end else if (row.op == op_flush) begin
            line_dirty = 1'b0;
        end
        if (wb_due) begin
            check_block(wb_block);
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------

    initial begin : main
        cpu_req = '0;
        csr_flush_order = 1'b0;
        rst_n = 1'b0;
        line_valid = 1'b0;
        line_dirty = 1'b0;
        line_base = '0;
        reset_shadow();
        build_table();
        // Same start state again for the run itself
        reset_shadow();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end
        $display("Summary: %0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Budget of 400 cycles for every row
    initial begin : watchdog
        wait (table_ready);
        #(rows.size() * cycles_per_row * clk_period);
        $display("Timeout: the cache did not finish the table within %0d cycles",
                 rows.size() * cycles_per_row);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rtl/dcache_pkg.sv
rtl/dcache_line_store.sv
rtl/dcache_burst_ctrl.sv
rtl/dcache_top.sv
bench/mem_burst_model.sv
bench/tb_dcache.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the dcache testbench with Verilator and run it

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache \
    -f files.f -o sim_dcache \
    && ./obj_dir/sim_dcache > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"

cat sim.log 2>/dev/null

grep -q "ALL TESTS PASSED" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
